//--- design/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 instr_valid_i,
  input  rv_core_pkg::instr_u  instr_i,
  output logic                 credit_o,
  output logic                 retire_valid_o,
  output rv_core_pkg::retire_t retire_o
);

  // Buffer head to decode
  logic                head_valid;
  rv_core_pkg::instr_u head;

  // Register file read ports
  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a;
  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b;
  logic [rv_core_pkg::XLEN-1:0]       rdata_a;
  logic [rv_core_pkg::XLEN-1:0]       rdata_b;

  // Pipe between stages
  rv_core_pkg::id_ex_t  id_ex;
  rv_core_pkg::retire_t ex_fwd;
  logic                 ex_fwd_valid;

  ////////////////////
  // Instruction buffer
  ////////////////////
  rv_fetch_buffer i_fetch_buffer (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .credit_o       ( credit_o       ),
    .head_valid_o   ( head_valid     ),
    .head_o         ( head           )
  );

  ////////////////////
  // ID stage
  ////////////////////
  rv_id_stage i_id_stage (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .head_valid_i   ( head_valid     ),
    .head_i         ( head           ),
    .raddr_a_o      ( raddr_a        ),
    .raddr_b_o      ( raddr_b        ),
    .rdata_a_i      ( rdata_a        ),
    .rdata_b_i      ( rdata_b        ),
    .ex_fwd_i       ( ex_fwd         ),
    .ex_fwd_valid_i ( ex_fwd_valid   ),
    // WB result forwarded, same cycle as the write
    .wb_i           ( retire_o       ),
    .wb_valid_i     ( retire_valid_o ),
    .id_ex_o        ( id_ex          )
  );

  ////////////////////
  // EX stage
  ////////////////////
  rv_ex_stage i_ex_stage (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .id_ex_i        ( id_ex          ),
    .ex_fwd_o       ( ex_fwd         ),
    .ex_fwd_valid_o ( ex_fwd_valid   ),
    .wb_o           ( retire_o       ),
    .wb_valid_o     ( retire_valid_o )
  );

  // Write-back shares the retire payload
  rv_register_file i_register_file (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .raddr_a_i      ( raddr_a        ),
    .raddr_b_i      ( raddr_b        ),
    .rdata_a_o      ( rdata_a        ),
    .rdata_b_o      ( rdata_b        ),
    .wr_i           ( retire_o       ),
    .wr_valid_i     ( retire_valid_o )
  );

endmodule

//--- design/rv_core_pkg.sv
package rv_core_pkg;

  ////////////////////
  // Widths and sizes
  ////////////////////

  // Data path width
  localparam int unsigned XLEN        = 32;
  // Register index and count
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned NUM_REGS    = 32;
  // Buffer entries, equal to the credits the sender starts with
  localparam int unsigned FETCH_DEPTH = 4;
  // Occupancy counter, holds 0 to FETCH_DEPTH
  localparam int unsigned CREDIT_W    = 3;
  // Buffer pointer width
  localparam int unsigned FETCH_PTR_W = $clog2(FETCH_DEPTH);

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes kept in this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 values shared by both formats
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  ////////////////////
  // Instruction views
  ////////////////////

  // Register-register format
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_r_t;

  // Register-immediate format
  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_i_t;

  // Same 32-bit word, two decodings
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  ////////////////////
  // Pipe payloads
  ////////////////////

  // ID/EX pipe
  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
  } id_ex_t;

  // EX/WB pipe, also the write port and retire payload
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
    logic [XLEN-1:0]       wdata;
  } retire_t;

endpackage

//--- design/rv_ex_stage.sv
`timescale 1ns/10ps

module rv_ex_stage (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  rv_core_pkg::id_ex_t  id_ex_i,
  output rv_core_pkg::retire_t ex_fwd_o,
  output logic                 ex_fwd_valid_o,
  output rv_core_pkg::retire_t wb_o,
  output logic                 wb_valid_o
);

  logic [rv_core_pkg::XLEN-1:0] a;
  logic [rv_core_pkg::XLEN-1:0] b;
  logic [4:0]                   shamt;
  logic [rv_core_pkg::XLEN-1:0] result;

  assign a     = id_ex_i.operand_a;
  assign b     = id_ex_i.operand_b;
  // Shift amount from low bits of operand b
  assign shamt = b[4:0];

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      rv_core_pkg::ALU_SUB:  result = a - b;
      rv_core_pkg::ALU_AND:  result = a & b;
      rv_core_pkg::ALU_OR:   result = a | b;
      rv_core_pkg::ALU_XOR:  result = a ^ b;
      // Compares give 0 or 1
      rv_core_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv_core_pkg::ALU_SLTU: result = {31'b0, a < b};
      rv_core_pkg::ALU_SLL:  result = a << shamt;
      rv_core_pkg::ALU_SRL:  result = a >> shamt;
      rv_core_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      default:               result = a + b;
    endcase
  end

  // Result back to ID for the next instruction
  assign ex_fwd_o.rd    = id_ex_i.rd;
  assign ex_fwd_o.rf_we = id_ex_i.rf_we;
  assign ex_fwd_o.wdata = result;
  assign ex_fwd_valid_o = id_ex_i.valid;

  ////////////////////
  // EX/WB pipe
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
      wb_o       <= '0;
    end else begin
      wb_valid_o <= id_ex_i.valid;
      wb_o.rf_we <= id_ex_i.valid && id_ex_i.rf_we;
      // Payload
      wb_o.rd    <= id_ex_i.rd;
      wb_o.wdata <= result;
    end
  end

endmodule

//--- design/rv_fetch_buffer.sv
`timescale 1ns/10ps

module rv_fetch_buffer (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  rv_core_pkg::instr_u instr_i,
  output logic               credit_o,
  output logic               head_valid_o,
  output rv_core_pkg::instr_u head_o
);

  // Storage, no reset needed on payload
  rv_core_pkg::instr_u mem [rv_core_pkg::FETCH_DEPTH];

  logic [rv_core_pkg::FETCH_PTR_W-1:0] wr_ptr;
  logic [rv_core_pkg::FETCH_PTR_W-1:0] rd_ptr;
  logic [rv_core_pkg::CREDIT_W-1:0]    count;
  logic                                pop;

  // ID never stalls, so any stored word leaves at once
  assign pop          = (count != '0);
  assign head_valid_o = pop;
  assign head_o       = mem[rd_ptr];
  // One credit back per word handed to decode
  assign credit_o     = pop;

  // Sender respects credits, no overflow check
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      mem[wr_ptr] <= instr_i;
    end
  end

  // Pointers wrap on power-of-two depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (instr_valid_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count <= '0;
    end else begin
      case ({instr_valid_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- design/rv_id_stage.sv
`timescale 1ns/10ps

module rv_id_stage (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               head_valid_i,
  input  rv_core_pkg::instr_u                head_i,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_o,
  input  logic [rv_core_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [rv_core_pkg::XLEN-1:0]       rdata_b_i,
  input  rv_core_pkg::retire_t               ex_fwd_i,
  input  logic                               ex_fwd_valid_i,
  input  rv_core_pkg::retire_t               wb_i,
  input  logic                               wb_valid_i,
  output rv_core_pkg::id_ex_t                id_ex_o
);

  rv_core_pkg::alu_op_e         alu_op;
  logic                         is_op;
  logic                         is_op_imm;
  logic [rv_core_pkg::XLEN-1:0] imm_sext;
  logic [rv_core_pkg::XLEN-1:0] fwd_a;
  logic [rv_core_pkg::XLEN-1:0] fwd_b;

  // Operand source: x0, then EX, then WB, then register file
  function automatic logic [rv_core_pkg::XLEN-1:0] fwd_sel(
    input logic [rv_core_pkg::REG_ADDR_W-1:0] addr,
    input logic [rv_core_pkg::XLEN-1:0]       rf_data
  );
    logic [rv_core_pkg::XLEN-1:0] res;
    if (addr == '0) begin
      res = '0;
    end else if (ex_fwd_valid_i && ex_fwd_i.rf_we && (ex_fwd_i.rd == addr)) begin
      res = ex_fwd_i.wdata;
    end else if (wb_valid_i && wb_i.rf_we && (wb_i.rd == addr)) begin
      res = wb_i.wdata;
    end else begin
      res = rf_data;
    end
    return res;
  endfunction

  ////////////////////
  // Decode
  ////////////////////

  assign is_op     = (head_i.r.opcode == rv_core_pkg::OPC_OP);
  assign is_op_imm = (head_i.i.opcode == rv_core_pkg::OPC_OP_IMM);

  // Read addresses straight from the word, rs2 unused for immediates
  assign raddr_a_o = head_i.r.rs1;
  assign raddr_b_o = head_i.r.rs2;

  // 12-bit immediate widened with its sign
  assign imm_sext = {{(rv_core_pkg::XLEN-12){head_i.i.imm12[11]}}, head_i.i.imm12};

  always_comb begin
    alu_op = rv_core_pkg::ALU_ADD;
    case (head_i.r.funct3)
      rv_core_pkg::F3_ADD: begin
        // SUB only in register form, funct7 bit 5
        if (is_op && head_i.r.funct7[5]) begin
          alu_op = rv_core_pkg::ALU_SUB;
        end
      end
      rv_core_pkg::F3_SLL:  alu_op = rv_core_pkg::ALU_SLL;
      rv_core_pkg::F3_SLT:  alu_op = rv_core_pkg::ALU_SLT;
      rv_core_pkg::F3_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
      rv_core_pkg::F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
      rv_core_pkg::F3_SR: begin
        // Arithmetic flag sits in funct7 or in imm12 bit 10
        if ((is_op && head_i.r.funct7[5]) || (is_op_imm && head_i.i.imm12[10])) begin
          alu_op = rv_core_pkg::ALU_SRA;
        end else begin
          alu_op = rv_core_pkg::ALU_SRL;
        end
      end
      rv_core_pkg::F3_OR:   alu_op = rv_core_pkg::ALU_OR;
      default:              alu_op = rv_core_pkg::ALU_AND;
    endcase
  end

  // Forwarded operands
  always_comb begin
    fwd_a = fwd_sel(head_i.r.rs1, rdata_a_i);
    fwd_b = fwd_sel(head_i.r.rs2, rdata_b_i);
  end

  ////////////////////
  // ID/EX pipe
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o <= '0;
    end else begin
      // Control bits
      id_ex_o.valid     <= head_valid_i;
      // Unknown opcodes still retire, without a write
      id_ex_o.rf_we     <= head_valid_i && (is_op || is_op_imm);
      // Payload
      id_ex_o.alu_op    <= alu_op;
      id_ex_o.operand_a <= fwd_a;
      id_ex_o.operand_b <= is_op_imm ? imm_sext : fwd_b;
      id_ex_o.rd        <= head_i.r.rd;
    end
  end

endmodule

//--- design/rv_register_file.sv
`timescale 1ns/10ps

module rv_register_file (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  input  rv_core_pkg::retire_t               wr_i,
  input  logic                               wr_valid_i
);

  // x1 to x31 only, x0 has no storage
  logic [rv_core_pkg::XLEN-1:0] regs [rv_core_pkg::NUM_REGS-1:1];
  logic                         we;

  // Drop writes aimed at x0
  assign we = wr_valid_i && wr_i.rf_we && (wr_i.rd != '0);

  // Single write port
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < rv_core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_i.rd] <= wr_i.wdata;
    end
  end

  // Combinational reads, x0 forced to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- dv/rv_clk_gen.sv
`timescale 1ns/10ps

module rv_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset low for ten cycles, released away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- dv/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

  localparam int unsigned NUM_INSTR    = 400;
  localparam int unsigned SEND_CYCLES  = 4000;
  localparam int unsigned DRAIN_CYCLES = 50;
  localparam int unsigned RESET_CYCLES = 100;
  // Longer than buffer plus pipe latency
  localparam int unsigned QUIET_CYCLES = 8;

  // One sent word plus what the model needs to know about it
  typedef struct packed {
    logic                 legal;
    logic                 imm_form;
    rv_core_pkg::alu_op_e op;
    rv_core_pkg::instr_u  word;
  } sent_instr_t;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  rv_core_pkg::instr_u  instr;
  logic                 credit;
  logic                 retire_valid;
  rv_core_pkg::retire_t retire;

  logic [31:0]                  lcg_state;
  logic [rv_core_pkg::XLEN-1:0] model_regs [rv_core_pkg::NUM_REGS];
  sent_instr_t                  pending [$];
  int unsigned                  credits;
  int unsigned                  sent;
  int unsigned                  returned;

  rv_clk_gen i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  rv_core i_dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .instr_valid_i  ( instr_valid  ),
    .instr_i        ( instr        ),
    .credit_o       ( credit       ),
    .retire_valid_o ( retire_valid ),
    .retire_o       ( retire       )
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopping at first error");
  endtask

  // LCG, upper bits are the useful ones
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Random RV32I ALU word, registers x0..x7 so dependencies are common
  function automatic sent_instr_t make_instr();
    sent_instr_t t;
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    r          = lcg_next();
    t.op       = rv_core_pkg::alu_op_e'(r[31:28] % 4'd10);
    t.imm_form = r[27];
    t.legal    = (r[26:23] != 4'hf);
    rd         = {2'b00, r[22:20]};
    rs1        = {2'b00, r[19:17]};
    rs2        = {2'b00, r[16:14]};
    imm        = r[13:2];
    // No immediate SUB in RV32I
    if (t.imm_form && (t.op == rv_core_pkg::ALU_SUB)) begin
      t.op = rv_core_pkg::ALU_ADD;
    end
    case (t.op)
      rv_core_pkg::ALU_SUB:  f3 = rv_core_pkg::F3_ADD;
      rv_core_pkg::ALU_SLL:  f3 = rv_core_pkg::F3_SLL;
      rv_core_pkg::ALU_SLT:  f3 = rv_core_pkg::F3_SLT;
      rv_core_pkg::ALU_SLTU: f3 = rv_core_pkg::F3_SLTU;
      rv_core_pkg::ALU_XOR:  f3 = rv_core_pkg::F3_XOR;
      rv_core_pkg::ALU_SRL:  f3 = rv_core_pkg::F3_SR;
      rv_core_pkg::ALU_SRA:  f3 = rv_core_pkg::F3_SR;
      rv_core_pkg::ALU_OR:   f3 = rv_core_pkg::F3_OR;
      rv_core_pkg::ALU_AND:  f3 = rv_core_pkg::F3_AND;
      default:               f3 = rv_core_pkg::F3_ADD;
    endcase
    // SUB and SRA carry the 0100000 pattern
    f7 = ((t.op == rv_core_pkg::ALU_SUB) || (t.op == rv_core_pkg::ALU_SRA)) ? 7'h20 : 7'h00;
    // Immediate shifts keep only shamt plus the pattern
    if ((t.op == rv_core_pkg::ALU_SLL) || (f3 == rv_core_pkg::F3_SR)) begin
      imm = {f7, imm[4:0]};
    end
    if (!t.legal) begin
      // Branch opcode, outside the kept scope
      t.word = {f7, rs2, rs1, f3, rd, 7'b1100011};
    end else if (t.imm_form) begin
      t.word = {imm, rs1, f3, rd, rv_core_pkg::OPC_OP_IMM};
    end else begin
      t.word = {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
    end
    return t;
  endfunction

  // Architectural result from the register model
  function automatic logic [31:0] model_result(input sent_instr_t t);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    a = model_regs[t.word.r.rs1];
    if (t.imm_form) begin
      b = {{20{t.word.i.imm12[11]}}, t.word.i.imm12};
    end else begin
      b = model_regs[t.word.r.rs2];
    end
    case (t.op)
      rv_core_pkg::ALU_SUB:  res = a - b;
      rv_core_pkg::ALU_AND:  res = a & b;
      rv_core_pkg::ALU_OR:   res = a | b;
      rv_core_pkg::ALU_XOR:  res = a ^ b;
      // Signed order equals unsigned order with sign bits flipped
      rv_core_pkg::ALU_SLT:  res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      rv_core_pkg::ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      rv_core_pkg::ALU_SLL:  res = a << b[4:0];
      rv_core_pkg::ALU_SRL:  res = a >> b[4:0];
      // Logical shift, vacated top bits filled with the sign
      rv_core_pkg::ALU_SRA:  res = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
      default:               res = a + b;
    endcase
    return res;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  // In-order retire against the oldest outstanding word
  task automatic check_retire();
    sent_instr_t t;
    logic [31:0] exp;
    assert (pending.size() != 0)
      else stop_on_error("Retire pulse arrived with no instruction outstanding");
    t   = pending.pop_front();
    exp = model_result(t);
    assert (retire.rd == t.word.r.rd)
      else stop_on_error($sformatf("Mismatch retire_o.rd: got %h expected %h",
                                   retire.rd, t.word.r.rd));
    assert (retire.rf_we == t.legal)
      else stop_on_error($sformatf("Mismatch retire_o.rf_we: got %h expected %h",
                                   retire.rf_we, t.legal));
    if (t.legal) begin
      assert (retire.wdata == exp)
        else stop_on_error($sformatf("Mismatch retire_o.wdata: got %h expected %h",
                                     retire.wdata, exp));
      // x0 stays zero in the model
      if (t.word.r.rd != '0) begin
        model_regs[t.word.r.rd] = exp;
      end
    end
  endtask

  // One cycle of checking and driving, called at the falling edge
  task automatic cycle_step(input logic may_send);
    sent_instr_t t;
    logic [31:0] r;
    if (retire_valid) begin
      check_retire();
    end
    if (credit) begin
      assert (credits < rv_core_pkg::FETCH_DEPTH)
        else stop_on_error("Credit returned while the sender already held all credits");
      credits++;
      returned++;
    end
    r = lcg_next();
    // About one idle cycle in four
    if (may_send && (credits != 0) && (r[31:30] != 2'b00)) begin
      t           = make_instr();
      instr_valid = 1'b1;
      instr       = t.word;
      pending.push_back(t);
      credits--;
      sent++;
    end else begin
      instr_valid = 1'b0;
      instr       = r;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int unsigned wait_cycles;
    lcg_state   = 32'd30;
    instr_valid = 1'b0;
    instr       = '0;
    credits     = rv_core_pkg::FETCH_DEPTH;
    sent        = 0;
    returned    = 0;
    for (int i = 0; i < rv_core_pkg::NUM_REGS; i++) begin
      model_regs[i] = '0;
    end

    wait_cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      wait_cycles++;
      assert (wait_cycles < RESET_CYCLES) else stop_on_error("Reset never released");
    end

    // Send phase
    wait_cycles = 0;
    while (sent < NUM_INSTR) begin
      @(negedge clk);
      wait_cycles++;
      assert (wait_cycles < SEND_CYCLES)
        else stop_on_error("Timeout while sending, credits did not come back");
      cycle_step(1'b1);
    end

    // Drain phase
    wait_cycles = 0;
    while (pending.size() != 0) begin
      @(negedge clk);
      wait_cycles++;
      assert (wait_cycles < DRAIN_CYCLES)
        else stop_on_error("Timeout waiting for outstanding instructions to retire");
      cycle_step(1'b0);
    end

    // Empty pipe, so any further retire or credit is an extra one
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      cycle_step(1'b0);
    end

    assert (returned == sent) else stop_on_error("Returned credits differ from sent count");

    $display("Everything OK");
    $finish;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim

# Exit status of the simulator is not used, the log decides
./obj_dir/rv_core_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Something failed" "$LOG" || ! grep -q "Everything OK" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"

//--- rv_core.f
design/rv_core_pkg.sv
design/rv_fetch_buffer.sv
design/rv_register_file.sv
design/rv_id_stage.sv
design/rv_ex_stage.sv
design/rv_core.sv
dv/rv_clk_gen.sv
dv/rv_core_tb.sv
